// File: Makefile
# Verilator build for the execute stage testbench

VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_exu_top
FILELIST  ?= exu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: exu.f
+incdir+.
exu_pkg.sv
exu_operand_mux.sv
exu_alu.sv
exu_csr_alu.sv
exu_branch.sv
exu_mem_latch.sv
exu_top.sv
tb_exu_top.sv

// File: exu_alu.sv
/*
 * integer alu of the execute stage
 * add, sub, compares, logic ops, shifts and pass-through
 * less and zero flags for the branch unit
 */

`default_nettype none

`include "exu_cfg.svh"

module exu_alu import exu_pkg::*; (
    input  wire [`EXU_XLEN-1:0]  op_a,
    input  wire [`EXU_XLEN-1:0]  op_b,
    input  wire alu_op_e         alu_op,
    output logic [`EXU_XLEN-1:0] result,
    output logic                 less,
    output logic                 zero
);

    localparam int MSB = `EXU_XLEN - 1;

    logic [`EXU_XLEN-1:0] sum;
    logic [`EXU_XLEN:0]   diff_ext;
    logic [`EXU_XLEN-1:0] diff;
    logic                 borrow;
    logic                 less_u;
    logic [4:0]           shamt;

    // ==================================================
    // shared adder and subtractor
    // ==================================================
    assign sum      = op_a + op_b;
    assign diff_ext = {1'b0, op_a} - {1'b0, op_b};
    assign diff     = diff_ext[MSB:0];
    assign borrow   = diff_ext[`EXU_XLEN];

    // unsigned compare is the borrow out
    assign less_u = borrow;

    // signed compare: differing signs decide directly, else no overflow
    assign less = (op_a[MSB] != op_b[MSB]) ? op_a[MSB] : diff[MSB];

    assign zero = (diff == '0);

    assign shamt = op_b[4:0];

    // ==================================================
    // result select
    // ==================================================
    always_comb begin
        case (alu_op)
            ALU_ADD:  result = sum;
            ALU_SUB:  result = diff;
            ALU_SLT:  result = {{MSB{1'b0}}, less};
            ALU_SLTU: result = {{MSB{1'b0}}, less_u};
            ALU_OR:   result = op_a | op_b;
            ALU_AND:  result = op_a & op_b;
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = $unsigned($signed(op_a) >>> shamt);
            // lui and csr reads take operand b unchanged
            ALU_PASS: result = op_b;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: exu_branch.sv
/*
 * branch unit of the execute stage
 * target address, taken decision, fetch and decode flush
 */

`default_nettype none

`include "exu_cfg.svh"

module exu_branch import exu_pkg::*; (
    input  wire [`EXU_XLEN-1:0]  pc,
    input  wire [`EXU_XLEN-1:0]  imm,
    input  wire [`EXU_XLEN-1:0]  rs1_val,
    input  wire [`EXU_XLEN-1:0]  csr_val,
    input  wire                  less,
    input  wire                  zero,
    input  wire br_cond_e        br_cond,
    input  wire tgt_sel_e        tgt_sel,
    input  wire                  op_valid,
    output logic [`EXU_XLEN-1:0] branch_target,
    output logic                 branch_taken,
    output logic                 flush_if,
    output logic                 flush_id
);

    logic [`EXU_XLEN-1:0] base;
    logic [`EXU_XLEN-1:0] raw_target;
    logic                 cond_met;

    always_comb begin
        case (tgt_sel)
            TGT_PC:  base = pc;
            TGT_RS1: base = rs1_val;
            TGT_CSR: base = csr_val;
            default: base = pc;
        endcase
    end

    assign raw_target = base + imm;

    // jalr drops bit 0 of the sum
    assign branch_target = {raw_target[`EXU_XLEN-1:1],
                            (tgt_sel == TGT_RS1) ? 1'b0 : raw_target[0]};

    always_comb begin
        case (br_cond)
            BR_EQ:   cond_met = zero;
            BR_NE:   cond_met = ~zero;
            BR_LT:   cond_met = less;
            BR_GE:   cond_met = ~less;
            BR_JUMP: cond_met = 1'b1;
            default: cond_met = 1'b0;
        endcase
    end

    // a bubble never redirects
    assign branch_taken = op_valid & cond_met;
    assign flush_if     = branch_taken;
    assign flush_id     = branch_taken;

endmodule

`default_nettype wire

// File: exu_cfg.svh
/*
 * execute stage configuration macros
 * data width, register index width, CSR index width
 */

`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// data and address width
`define EXU_XLEN 32

// architectural register index
`define EXU_REG_W 5

// internal csr index: 0 mstatus, 1 mtvec, 2 mepc, 3 mcause
`define EXU_CSR_W 2

`endif

// File: exu_csr_alu.sv
/*
 * csr unit of the execute stage
 * write value for csrrw and csrrs, mepc value for ecall
 */

`default_nettype none

`include "exu_cfg.svh"

module exu_csr_alu import exu_pkg::*; (
    input  wire [`EXU_XLEN-1:0]  rs1_val,
    input  wire [`EXU_XLEN-1:0]  csr_val,
    input  wire [`EXU_XLEN-1:0]  pc,
    input  wire csr_op_e         csr_op,
    output logic [`EXU_XLEN-1:0] result
);

    always_comb begin
        case (csr_op)
            CSR_RW:    result = rs1_val;
            CSR_RS:    result = csr_val | rs1_val;
            // trapping pc goes to mepc
            CSR_ECALL: result = pc;
            default:   result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: exu_mem_latch.sv
/*
 * execute to memory pipeline register
 * valid and write enables under reset, payload held on bubbles
 */

`default_nettype none

`include "exu_cfg.svh"

module exu_mem_latch (
    input  wire                  clock,
    input  wire                  reset,
    input  wire                  op_valid,
    input  wire [`EXU_XLEN-1:0]  pc,
    input  wire [`EXU_XLEN-1:0]  inst,
    input  wire [`EXU_REG_W-1:0] rd,
    input  wire [`EXU_XLEN-1:0]  alu_result,
    input  wire [`EXU_XLEN-1:0]  csr_result,
    input  wire [`EXU_XLEN-1:0]  store_data,
    input  wire                  write_gpr,
    input  wire                  write_csr,
    input  wire                  mem_to_reg,
    input  wire                  write_mem,
    input  wire [1:0]            mem_size,
    input  wire                  mem_unsigned,
    output logic                  mem_valid,
    output logic [`EXU_XLEN-1:0]  mem_pc,
    output logic [`EXU_XLEN-1:0]  mem_inst,
    output logic [`EXU_REG_W-1:0] mem_rd,
    output logic [`EXU_XLEN-1:0]  mem_alu_result,
    output logic [`EXU_XLEN-1:0]  mem_csr_result,
    output logic [`EXU_XLEN-1:0]  mem_store_data,
    output logic                  mem_write_gpr,
    output logic                  mem_write_csr,
    output logic                  mem_mem_to_reg,
    output logic                  mem_write_mem,
    output logic [1:0]            mem_mem_size,
    output logic                  mem_mem_unsigned
);

    // ==================================================
    // control: valid and write enables
    // ==================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            mem_valid     <= 1'b0;
            mem_write_gpr <= 1'b0;
            mem_write_csr <= 1'b0;
            mem_write_mem <= 1'b0;
        end else begin
            mem_valid     <= op_valid;
            // bubble clears every write strobe
            mem_write_gpr <= op_valid & write_gpr;
            mem_write_csr <= op_valid & write_csr;
            mem_write_mem <= op_valid & write_mem;
        end
    end

    // ==================================================
    // payload
    // ==================================================
    always_ff @(posedge clock) begin
        if (op_valid) begin
            mem_pc           <= pc;
            mem_inst         <= inst;
            mem_rd           <= rd;
            mem_alu_result   <= alu_result;
            mem_csr_result   <= csr_result;
            mem_store_data   <= store_data;
            mem_mem_to_reg   <= mem_to_reg;
            mem_mem_size     <= mem_size;
            mem_mem_unsigned <= mem_unsigned;
        end
    end

    a_valid_after_reset: assert property (@(posedge clock) reset |=> !mem_valid);

    a_write_needs_valid: assert property (@(posedge clock) disable iff (reset)
        (mem_write_gpr || mem_write_csr || mem_write_mem) |-> mem_valid);

    // a load-store mix would mean broken decode upstream
    a_no_gpr_and_store: assert property (@(posedge clock) disable iff (reset)
        op_valid |-> !(write_gpr && write_mem));

endmodule

`default_nettype wire

// File: exu_operand_mux.sv
/*
 * operand unit of the execute stage
 * forwarding override for rs1, rs2 and csr
 * alu operand a and b selection
 */

`default_nettype none

`include "exu_cfg.svh"

module exu_operand_mux import exu_pkg::*; (
    input  wire [`EXU_XLEN-1:0] rs1_data,
    input  wire [`EXU_XLEN-1:0] rs2_data,
    input  wire [`EXU_XLEN-1:0] csr_data,
    input  wire                 fwd_rs1_hit,
    input  wire [`EXU_XLEN-1:0] fwd_rs1_data,
    input  wire                 fwd_rs2_hit,
    input  wire [`EXU_XLEN-1:0] fwd_rs2_data,
    input  wire                 fwd_csr_hit,
    input  wire [`EXU_XLEN-1:0] fwd_csr_data,
    input  wire [`EXU_XLEN-1:0] pc,
    input  wire [`EXU_XLEN-1:0] imm,
    input  wire src1_sel_e      src1_sel,
    input  wire src2_sel_e      src2_sel,
    output logic [`EXU_XLEN-1:0] rs1_val,
    output logic [`EXU_XLEN-1:0] rs2_val,
    output logic [`EXU_XLEN-1:0] csr_val,
    output logic [`EXU_XLEN-1:0] op_a,
    output logic [`EXU_XLEN-1:0] op_b
);

    localparam logic [`EXU_XLEN-1:0] PC_STEP = `EXU_XLEN'd4;

    // forwarded value wins over the register read
    assign rs1_val = fwd_rs1_hit ? fwd_rs1_data : rs1_data;
    assign rs2_val = fwd_rs2_hit ? fwd_rs2_data : rs2_data;
    assign csr_val = fwd_csr_hit ? fwd_csr_data : csr_data;

    assign op_a = (src1_sel == SRC1_PC) ? pc : rs1_val;

    always_comb begin
        case (src2_sel)
            SRC2_RS2:  op_b = rs2_val;
            SRC2_IMM:  op_b = imm;
            // link address for jal and jalr
            SRC2_FOUR: op_b = PC_STEP;
            SRC2_CSR:  op_b = csr_val;
            default:   op_b = rs2_val;
        endcase
    end

endmodule

`default_nettype wire

// File: exu_pkg.sv
/*
 * execute stage types
 * alu opcodes, operand selects, branch conditions,
 * branch target bases and csr operations
 */

`default_nettype none

package exu_pkg;

    // ==================================================
    // alu
    // ==================================================
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_OR,
        ALU_AND,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS
    } alu_op_e;

    typedef enum logic [0:0] {SRC1_RS1, SRC1_PC} src1_sel_e;

    typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR, SRC2_CSR} src2_sel_e;

    // ==================================================
    // branch and csr
    // ==================================================
    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_JUMP} br_cond_e;

    // TGT_CSR serves mret-style returns through mepc
    typedef enum logic [1:0] {TGT_PC, TGT_RS1, TGT_CSR} tgt_sel_e;

    typedef enum logic [1:0] {CSR_NONE, CSR_RW, CSR_RS, CSR_ECALL} csr_op_e;

endpackage

`default_nettype wire

// File: exu_top.sv
/*
 * execute stage top
 * operand unit, alu, csr unit, branch unit and ex/mem register
 */

`default_nettype none

`include "exu_cfg.svh"

module exu_top import exu_pkg::*; (
    input  wire                   clock,
    input  wire                   reset,
    input  wire [`EXU_XLEN-1:0]   pc,
    input  wire [`EXU_XLEN-1:0]   inst,
    input  wire [`EXU_REG_W-1:0]  rd,
    input  wire [`EXU_XLEN-1:0]   rs1_data,
    input  wire [`EXU_XLEN-1:0]   rs2_data,
    input  wire [`EXU_XLEN-1:0]   csr_data,
    input  wire [`EXU_XLEN-1:0]   imm,
    input  wire alu_op_e          alu_op,
    input  wire src1_sel_e        src1_sel,
    input  wire src2_sel_e        src2_sel,
    input  wire br_cond_e         br_cond,
    input  wire tgt_sel_e         tgt_sel,
    input  wire csr_op_e          csr_op,
    input  wire                   write_gpr,
    input  wire                   write_csr,
    input  wire                   mem_to_reg,
    input  wire                   write_mem,
    input  wire [1:0]             mem_size,
    input  wire                   mem_unsigned,
    input  wire                   op_valid,
    input  wire                   fwd_rs1_hit,
    input  wire [`EXU_XLEN-1:0]   fwd_rs1_data,
    input  wire                   fwd_rs2_hit,
    input  wire [`EXU_XLEN-1:0]   fwd_rs2_data,
    input  wire                   fwd_csr_hit,
    input  wire [`EXU_XLEN-1:0]   fwd_csr_data,
    // fetch redirect
    output logic [`EXU_XLEN-1:0]  branch_target,
    output logic                  branch_taken,
    output logic                  flush_if,
    output logic                  flush_id,
    // memory stage
    output logic                  mem_valid,
    output logic [`EXU_XLEN-1:0]  mem_pc,
    output logic [`EXU_XLEN-1:0]  mem_inst,
    output logic [`EXU_REG_W-1:0] mem_rd,
    output logic [`EXU_XLEN-1:0]  mem_alu_result,
    output logic [`EXU_XLEN-1:0]  mem_csr_result,
    output logic [`EXU_XLEN-1:0]  mem_store_data,
    output logic                  mem_write_gpr,
    output logic                  mem_write_csr,
    output logic                  mem_mem_to_reg,
    output logic                  mem_write_mem,
    output logic [1:0]            mem_mem_size,
    output logic                  mem_mem_unsigned
);

    logic [`EXU_XLEN-1:0] rs1_val;
    logic [`EXU_XLEN-1:0] rs2_val;
    logic [`EXU_XLEN-1:0] csr_val;
    logic [`EXU_XLEN-1:0] op_a;
    logic [`EXU_XLEN-1:0] op_b;
    logic [`EXU_XLEN-1:0] alu_result;
    logic [`EXU_XLEN-1:0] csr_result;
    logic                 less;
    logic                 zero;

    exu_operand_mux u_operand_mux (
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .csr_data     (csr_data),
        .fwd_rs1_hit  (fwd_rs1_hit),
        .fwd_rs1_data (fwd_rs1_data),
        .fwd_rs2_hit  (fwd_rs2_hit),
        .fwd_rs2_data (fwd_rs2_data),
        .fwd_csr_hit  (fwd_csr_hit),
        .fwd_csr_data (fwd_csr_data),
        .pc           (pc),
        .imm          (imm),
        .src1_sel     (src1_sel),
        .src2_sel     (src2_sel),
        .rs1_val      (rs1_val),
        .rs2_val      (rs2_val),
        .csr_val      (csr_val),
        .op_a         (op_a),
        .op_b         (op_b)
    );

    exu_alu u_alu (
        .op_a   (op_a),
        .op_b   (op_b),
        .alu_op (alu_op),
        .result (alu_result),
        .less   (less),
        .zero   (zero)
    );

    exu_csr_alu u_csr_alu (
        .rs1_val (rs1_val),
        .csr_val (csr_val),
        .pc      (pc),
        .csr_op  (csr_op),
        .result  (csr_result)
    );

    exu_branch u_branch (
        .pc            (pc),
        .imm           (imm),
        .rs1_val       (rs1_val),
        .csr_val       (csr_val),
        .less          (less),
        .zero          (zero),
        .br_cond       (br_cond),
        .tgt_sel       (tgt_sel),
        .op_valid      (op_valid),
        .branch_target (branch_target),
        .branch_taken  (branch_taken),
        .flush_if      (flush_if),
        .flush_id      (flush_id)
    );

    // rs2 after forwarding is the store data
    exu_mem_latch u_mem_latch (
        .clock            (clock),
        .reset            (reset),
        .op_valid         (op_valid),
        .pc               (pc),
        .inst             (inst),
        .rd               (rd),
        .alu_result       (alu_result),
        .csr_result       (csr_result),
        .store_data       (rs2_val),
        .write_gpr        (write_gpr),
        .write_csr        (write_csr),
        .mem_to_reg       (mem_to_reg),
        .write_mem        (write_mem),
        .mem_size         (mem_size),
        .mem_unsigned     (mem_unsigned),
        .mem_valid        (mem_valid),
        .mem_pc           (mem_pc),
        .mem_inst         (mem_inst),
        .mem_rd           (mem_rd),
        .mem_alu_result   (mem_alu_result),
        .mem_csr_result   (mem_csr_result),
        .mem_store_data   (mem_store_data),
        .mem_write_gpr    (mem_write_gpr),
        .mem_write_csr    (mem_write_csr),
        .mem_mem_to_reg   (mem_mem_to_reg),
        .mem_write_mem    (mem_write_mem),
        .mem_mem_size     (mem_mem_size),
        .mem_mem_unsigned (mem_mem_unsigned)
    );

endmodule

`default_nettype wire

// File: tb_exu_top.sv
/*
 * testbench for the execute stage
 * random alu, forwarding, branch, csr and bubble traffic
 * reference model with a one-cycle delayed compare of the ex/mem register
 */

`default_nettype none

`include "exu_cfg.svh"

module tb_exu_top import exu_pkg::*; ();

    typedef struct packed {
        logic [3:0]            ctrl;
        logic [`EXU_XLEN-1:0]  alu;
        logic [`EXU_XLEN-1:0]  csr;
        logic [`EXU_XLEN-1:0]  store;
        logic [`EXU_XLEN-1:0]  pc;
        logic [`EXU_XLEN-1:0]  inst;
        logic [`EXU_REG_W-1:0] rd;
        // mem_to_reg, size, unsigned
        logic [3:0]            attr;
        logic                  taken;
        logic [`EXU_XLEN-1:0]  target;
    } exp_t;

    logic                  clock = 1'b0;
    logic                  reset;
    logic [`EXU_XLEN-1:0]  pc;
    logic [`EXU_XLEN-1:0]  inst;
    logic [`EXU_REG_W-1:0] rd;
    logic [`EXU_XLEN-1:0]  rs1_data;
    logic [`EXU_XLEN-1:0]  rs2_data;
    logic [`EXU_XLEN-1:0]  csr_data;
    logic [`EXU_XLEN-1:0]  imm;
    alu_op_e               alu_op;
    src1_sel_e             src1_sel;
    src2_sel_e             src2_sel;
    br_cond_e              br_cond;
    tgt_sel_e              tgt_sel;
    csr_op_e               csr_op;
    logic                  write_gpr;
    logic                  write_csr;
    logic                  mem_to_reg;
    logic                  write_mem;
    logic [1:0]            mem_size;
    logic                  mem_unsigned;
    logic                  op_valid;
    logic                  fwd_rs1_hit;
    logic [`EXU_XLEN-1:0]  fwd_rs1_data;
    logic                  fwd_rs2_hit;
    logic [`EXU_XLEN-1:0]  fwd_rs2_data;
    logic                  fwd_csr_hit;
    logic [`EXU_XLEN-1:0]  fwd_csr_data;
    logic [`EXU_XLEN-1:0]  branch_target;
    logic                  branch_taken;
    logic                  flush_if;
    logic                  flush_id;
    logic                  mem_valid;
    logic [`EXU_XLEN-1:0]  mem_pc;
    logic [`EXU_XLEN-1:0]  mem_inst;
    logic [`EXU_REG_W-1:0] mem_rd;
    logic [`EXU_XLEN-1:0]  mem_alu_result;
    logic [`EXU_XLEN-1:0]  mem_csr_result;
    logic [`EXU_XLEN-1:0]  mem_store_data;
    logic                  mem_write_gpr;
    logic                  mem_write_csr;
    logic                  mem_mem_to_reg;
    logic                  mem_write_mem;
    logic [1:0]            mem_mem_size;
    logic                  mem_mem_unsigned;

    exp_t  cur;
    exp_t  prev;
    exp_t  exp_q[$];
    string phase;
    string prev_name;
    int    errors;
    int    checks;

    exu_top dut0 (.*);

    always #50 clock = ~clock;

    // ==================================================
    // reference model
    // ==================================================
    function automatic exp_t ref_exu(
        input logic                 valid,
        input logic [`EXU_XLEN-1:0] pc_in,
        input logic [`EXU_XLEN-1:0] imm_in,
        input logic [`EXU_XLEN-1:0] rs1,
        input logic [`EXU_XLEN-1:0] rs2,
        input logic [`EXU_XLEN-1:0] csr,
        input alu_op_e              op,
        input src1_sel_e            s1,
        input src2_sel_e            s2,
        input br_cond_e             cond,
        input tgt_sel_e             tgt,
        input csr_op_e              cop
    );
        exp_t                 e;
        logic [`EXU_XLEN-1:0] a;
        logic [`EXU_XLEN-1:0] b;
        logic [`EXU_XLEN-1:0] base;
        logic                 lt;
        e = '0;
        a = (s1 == SRC1_PC) ? pc_in : rs1;
        case (s2)
            SRC2_RS2:  b = rs2;
            SRC2_IMM:  b = imm_in;
            SRC2_FOUR: b = 32'd4;
            default:   b = csr;
        endcase
        lt = $signed(a) < $signed(b);
        case (op)
            ALU_ADD:  e.alu = a + b;
            ALU_SUB:  e.alu = a - b;
            ALU_SLT:  e.alu = `EXU_XLEN'(lt);
            ALU_SLTU: e.alu = `EXU_XLEN'(a < b);
            ALU_OR:   e.alu = a | b;
            ALU_AND:  e.alu = a & b;
            ALU_XOR:  e.alu = a ^ b;
            ALU_SLL:  e.alu = a << b[4:0];
            ALU_SRL:  e.alu = a >> b[4:0];
            ALU_SRA:  e.alu = $signed(a) >>> b[4:0];
            default:  e.alu = b;
        endcase
        case (cop)
            CSR_RW:    e.csr = rs1;
            CSR_RS:    e.csr = csr | rs1;
            CSR_ECALL: e.csr = pc_in;
            default:   e.csr = '0;
        endcase
        case (cond)
            BR_EQ:   e.taken = (a == b);
            BR_NE:   e.taken = (a != b);
            BR_LT:   e.taken = lt;
            BR_GE:   e.taken = !lt;
            BR_JUMP: e.taken = 1'b1;
            default: e.taken = 1'b0;
        endcase
        e.taken = e.taken & valid;
        base = (tgt == TGT_RS1) ? rs1 : (tgt == TGT_CSR) ? csr : pc_in;
        e.target = base + imm_in;
        if (tgt == TGT_RS1) begin
            e.target[0] = 1'b0;
        end
        e.store = rs2;
        e.pc = pc_in;
        return e;
    endfunction

    task automatic check_value(input string name, input string field,
                               input logic [31:0] exp_val, input logic [31:0] act_val);
        checks++;
        if (act_val !== exp_val) begin
            errors++;
            $display("ERROR %s %s: expected %h actual %h", name, field, exp_val, act_val);
        end
    endtask

    // ==================================================
    // compare process, sampled mid-cycle
    // ==================================================
    always @(negedge clock) begin
        cur = ref_exu(op_valid, pc, imm,
                      fwd_rs1_hit ? fwd_rs1_data : rs1_data,
                      fwd_rs2_hit ? fwd_rs2_data : rs2_data,
                      fwd_csr_hit ? fwd_csr_data : csr_data,
                      alu_op, src1_sel, src2_sel, br_cond, tgt_sel, csr_op);
        cur.ctrl = reset ? 4'b0 : {op_valid, op_valid & write_gpr,
                                   op_valid & write_csr, op_valid & write_mem};
        cur.inst = inst;
        cur.rd   = rd;
        cur.attr = {mem_to_reg, mem_size, mem_unsigned};
        if (exp_q.size() > 0) begin
            prev = exp_q.pop_front();
            check_value(prev_name, "mem_ctrl", 32'(prev.ctrl),
                        32'({mem_valid, mem_write_gpr, mem_write_csr, mem_write_mem}));
            if (prev.ctrl[3]) begin
                check_value(prev_name, "mem_alu_result", prev.alu, mem_alu_result);
                check_value(prev_name, "mem_csr_result", prev.csr, mem_csr_result);
                check_value(prev_name, "mem_store_data", prev.store, mem_store_data);
                check_value(prev_name, "mem_pc", prev.pc, mem_pc);
                check_value(prev_name, "mem_inst", prev.inst, mem_inst);
                check_value(prev_name, "mem_rd", 32'(prev.rd), 32'(mem_rd));
                check_value(prev_name, "mem_attr", 32'(prev.attr),
                            32'({mem_mem_to_reg, mem_mem_size, mem_mem_unsigned}));
            end
        end
        check_value(phase, "branch_taken", 32'(cur.taken), 32'(branch_taken));
        check_value(phase, "flush_if", 32'(cur.taken), 32'(flush_if));
        check_value(phase, "flush_id", 32'(cur.taken), 32'(flush_id));
        check_value(phase, "branch_target", cur.target, branch_target);
        exp_q.push_back(cur);
        prev_name = phase;
    end

    // ==================================================
    // stimulus helpers
    // ==================================================
    task automatic randomize_inputs(input logic valid);
        logic kind;
        kind = 1'($urandom());
        op_valid     <= valid;
        pc           <= $urandom() & ~32'h3;
        inst         <= $urandom();
        rd           <= 5'($urandom());
        rs1_data     <= $urandom();
        rs2_data     <= $urandom();
        csr_data     <= $urandom();
        imm          <= $urandom();
        alu_op       <= alu_op_e'(4'($urandom_range(0, 10)));
        src1_sel     <= src1_sel_e'(1'($urandom()));
        src2_sel     <= src2_sel_e'(2'($urandom()));
        br_cond      <= br_cond_e'(3'($urandom_range(0, 5)));
        tgt_sel      <= tgt_sel_e'(2'($urandom_range(0, 2)));
        csr_op       <= csr_op_e'(2'($urandom()));
        // gpr write and store stay exclusive
        write_gpr    <= kind;
        write_mem    <= ~kind & 1'($urandom());
        write_csr    <= 1'($urandom());
        mem_to_reg   <= 1'($urandom());
        mem_size     <= 2'($urandom());
        mem_unsigned <= 1'($urandom());
        fwd_rs1_hit  <= 1'($urandom());
        fwd_rs1_data <= $urandom();
        fwd_rs2_hit  <= 1'($urandom());
        fwd_rs2_data <= $urandom();
        fwd_csr_hit  <= 1'($urandom());
        fwd_csr_data <= $urandom();
    endtask

    // random bubble ahead of each instruction
    task automatic start_cycle(input string name);
        if ($urandom_range(0, 7) == 0) begin
            @(posedge clock);
            randomize_inputs(1'b0);
            phase = "bubble";
        end
        @(posedge clock);
        randomize_inputs(1'b1);
        phase = name;
    endtask

    task automatic wait_mem_idle(input int limit);
        int n;
        n = 0;
        while (mem_valid !== 1'b0 && n < limit) begin
            @(negedge clock);
            n++;
        end
        if (mem_valid !== 1'b0) begin
            errors++;
            $display("timeout: mem_valid still high after %0d cycles", limit);
        end
    endtask

    // ==================================================
    // test sequence
    // ==================================================
    initial begin
        logic [`EXU_XLEN-1:0] r1;
        logic [`EXU_XLEN-1:0] r2;
        int i;
        int c;
        int t;
        int k;
        void'($urandom(32'h7933));
        errors = 0;
        checks = 0;
        phase = "reset";
        reset = 1'b1;
        randomize_inputs(1'b0);
        repeat (5) @(posedge clock);
        // valid traffic with every write enable set while reset holds
        randomize_inputs(1'b1);
        write_gpr <= 1'b1;
        write_csr <= 1'b1;
        write_mem <= 1'b1;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        randomize_inputs(1'b0);
        wait_mem_idle(5);

        for (i = 0; i < 300; i++) begin
            start_cycle("alu");
            alu_op <= alu_op_e'(4'(i % 11));
        end

        // forwarded data always differs from the register read
        for (i = 0; i < 80; i++) begin
            start_cycle("forward");
            r1 = $urandom();
            r2 = $urandom();
            rs1_data     <= r1;
            fwd_rs1_data <= ~r1;
            rs2_data     <= r2;
            fwd_rs2_data <= r2 ^ 32'h5a5a_0001;
            fwd_rs1_hit  <= 1'($urandom());
            fwd_rs2_hit  <= 1'($urandom());
            write_gpr    <= 1'b0;
            write_mem    <= 1'b1;
        end

        for (c = 0; c < 6; c++) begin
            for (t = 0; t < 3; t++) begin
                for (k = 0; k < 5; k++) begin
                    start_cycle("branch");
                    br_cond     <= br_cond_e'(3'(c));
                    tgt_sel     <= tgt_sel_e'(2'(t));
                    src1_sel    <= SRC1_RS1;
                    src2_sel    <= SRC2_RS2;
                    fwd_rs1_hit <= 1'b0;
                    fwd_rs2_hit <= 1'b0;
                    r1 = $urandom();
                    case (k)
                        0: r2 = r1;
                        1: r2 = r1 + 1;
                        2: begin
                            r1 = 32'h8000_0000;
                            r2 = 32'h7fff_ffff;
                        end
                        3: begin
                            r1 = 32'h7fff_ffff;
                            r2 = 32'h8000_0000;
                        end
                        default: begin
                            r1 = 32'hffff_ffff;
                            r2 = 32'h0000_0000;
                        end
                    endcase
                    rs1_data <= r1;
                    rs2_data <= r2;
                end
            end
        end

        for (i = 0; i < 60; i++) begin
            start_cycle("csr");
            csr_op    <= csr_op_e'(2'(1 + i % 3));
            write_csr <= 1'b1;
        end

        @(posedge clock);
        randomize_inputs(1'b0);
        phase = "drain";
        wait_mem_idle(20);
        @(posedge clock);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
